// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // Data and register index widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Default data memory depth in words
    localparam int DMEM_WORDS_DEF = 64;

    // Major opcodes, instr[31:26]
    // Anything else decodes to a bubble
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    // R-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        fn_sll = 6'h00,
        fn_srl = 6'h02,
        fn_sra = 6'h03,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_xor = 6'h26,
        fn_slt = 6'h2a
    } funct_e;

    // ALU operations
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_sra, alu_lui_pass
    } alu_op_e;

endpackage

`default_nettype wire

// ==== hw/pipe_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

//////////////////////////////////////////////////
// ID/EX bundle
//////////////////////////////////////////////////

interface idex_if import cpu_pkg::*; ();

    // Control, cleared by reset in the producer
    logic      valid;
    logic      reg_w;
    logic      mem_r;
    logic      mem_w;

    // Operation and operands
    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    word_t     imm;
    logic      use_imm;

    // Source indices for forwarding, destination for write-back
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;

    modport producer (
        output valid, alu_op, op_a, op_b, imm, use_imm, rs, rt, rd, reg_w, mem_r, mem_w
    );

    modport consumer (
        input valid, alu_op, op_a, op_b, imm, use_imm, rs, rt, rd, reg_w, mem_r, mem_w
    );

endinterface

//////////////////////////////////////////////////
// EX/MEM bundle
//////////////////////////////////////////////////

interface exmem_if import cpu_pkg::*; ();

    logic      valid;
    // ALU result, also the load/store byte address
    word_t     result;
    // Forwarded rt value for sw
    word_t     store_data;
    reg_addr_t rd;
    logic      reg_w;
    logic      mem_r;
    logic      mem_w;

    modport producer (
        output valid, result, store_data, rd, reg_w, mem_r, mem_w
    );

    modport consumer (
        input valid, result, store_data, rd, reg_w, mem_r, mem_w
    );

endinterface

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  wire logic wb_reg_w,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    // Registers 1 to 31, r0 has no storage
    word_t regs [1:31];

    // Read port with write-through from WB
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_reg_w && (wb_rd == addr)) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_reg_w && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic in_valid,
    input  word_t     in_instr,
    output logic      in_ready,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    input  word_t     rs_data,
    input  word_t     rt_data,
    idex_if.producer  idex
);

    // ID register
    logic      id_valid;
    word_t     instr_q;

    // Instruction fields
    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t f_rs;
    reg_addr_t f_rt;
    reg_addr_t f_rd;

    // Decoded control
    logic      known;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      sign_ext;
    logic      reg_w;
    logic      mem_r;
    logic      mem_w;
    logic      uses_rs;
    logic      uses_rt;
    reg_addr_t dest;
    word_t     imm_ext;

    logic      hazard;
    logic      push;

    //////////////////////////////////////////////////
    // Instruction handshake
    //////////////////////////////////////////////////

    // Stall only comes from the load in EX, never from in_valid
    assign in_ready = ~hazard;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (in_ready) begin
            id_valid <= in_valid;
        end
    end

    // Instruction word, held during a stall
    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            instr_q <= in_instr;
        end
    end

    assign opcode  = opcode_e'(instr_q[31:26]);
    assign funct   = funct_e'(instr_q[5:0]);
    assign f_rs    = instr_q[25:21];
    assign f_rt    = instr_q[20:16];
    assign f_rd    = instr_q[15:11];

    // Register file read straight from the fields
    assign rs_addr = f_rs;
    assign rt_addr = f_rt;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    always_comb begin
        known    = 1'b1;
        alu_op   = alu_add;
        use_imm  = 1'b0;
        sign_ext = 1'b1;
        reg_w    = 1'b0;
        mem_r    = 1'b0;
        mem_w    = 1'b0;
        uses_rs  = 1'b1;
        uses_rt  = 1'b0;
        dest     = f_rt;
        case (opcode)
            op_rtype: begin
                dest    = f_rd;
                reg_w   = 1'b1;
                uses_rt = 1'b1;
                case (funct)
                    fn_add: alu_op = alu_add;
                    fn_sub: alu_op = alu_sub;
                    fn_and: alu_op = alu_and;
                    fn_or:  alu_op = alu_or;
                    fn_xor: alu_op = alu_xor;
                    fn_slt: alu_op = alu_slt;
                    // Shifts read only rt
                    fn_sll: begin
                        alu_op  = alu_sll;
                        uses_rs = 1'b0;
                    end
                    fn_srl: begin
                        alu_op  = alu_srl;
                        uses_rs = 1'b0;
                    end
                    fn_sra: begin
                        alu_op  = alu_sra;
                        uses_rs = 1'b0;
                    end
                    default: known = 1'b0;
                endcase
            end
            op_addi: begin
                use_imm = 1'b1;
                reg_w   = 1'b1;
            end
            op_andi: begin
                alu_op   = alu_and;
                use_imm  = 1'b1;
                sign_ext = 1'b0;
                reg_w    = 1'b1;
            end
            op_ori: begin
                alu_op   = alu_or;
                use_imm  = 1'b1;
                sign_ext = 1'b0;
                reg_w    = 1'b1;
            end
            op_lui: begin
                alu_op  = alu_lui_pass;
                use_imm = 1'b1;
                reg_w   = 1'b1;
                uses_rs = 1'b0;
            end
            op_lw: begin
                use_imm = 1'b1;
                reg_w   = 1'b1;
                mem_r   = 1'b1;
            end
            // Store data comes from rt
            op_sw: begin
                use_imm = 1'b1;
                mem_w   = 1'b1;
                uses_rt = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // Sign or zero extension of the 16-bit immediate
    assign imm_ext = sign_ext ? {{16{instr_q[15]}}, instr_q[15:0]} : {16'h0000, instr_q[15:0]};

    //////////////////////////////////////////////////
    // Load-use hazard
    //////////////////////////////////////////////////

    // Load in EX whose destination feeds this instruction
    assign hazard = id_valid && known && idex.valid && idex.mem_r && (idex.rd != '0) &&
                    ((uses_rs && (f_rs == idex.rd)) || (uses_rt && (f_rt == idex.rd)));

    // Unknown opcodes and stalls leave a bubble behind
    assign push = id_valid && known && !hazard;

    // ID/EX control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex.valid <= 1'b0;
            idex.reg_w <= 1'b0;
            idex.mem_r <= 1'b0;
            idex.mem_w <= 1'b0;
        end else begin
            idex.valid <= push;
            // r0 never written
            idex.reg_w <= push && reg_w && (dest != '0);
            idex.mem_r <= push && mem_r;
            idex.mem_w <= push && mem_w;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        idex.alu_op  <= alu_op;
        idex.op_a    <= rs_data;
        idex.op_b    <= rt_data;
        idex.imm     <= imm_ext;
        idex.use_imm <= use_imm;
        idex.rs      <= f_rs;
        idex.rt      <= f_rt;
        idex.rd      <= dest;
    end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic wb_reg_w,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    idex_if.consumer  idex,
    exmem_if.producer exmem
);

    logic       mem_fwd_ok;
    word_t      fwd_a;
    word_t      fwd_b;
    word_t      alu_b;
    logic [4:0] shamt;
    word_t      alu_out;

    //////////////////////////////////////////////////
    // Forwarding
    //////////////////////////////////////////////////

    // EX/MEM result is usable unless it is still a load address
    assign mem_fwd_ok = exmem.valid && exmem.reg_w && !exmem.mem_r;

    // Newest producer wins, r0 is never forwarded
    function automatic word_t fwd(
        reg_addr_t src,
        word_t     base,
        logic      mem_ok,
        reg_addr_t mem_rd,
        word_t     mem_val,
        logic      wb_ok,
        reg_addr_t wb_dst,
        word_t     wb_val
    );
        if (src == '0) begin
            return base;
        end else if (mem_ok && (mem_rd == src)) begin
            return mem_val;
        end else if (wb_ok && (wb_dst == src)) begin
            return wb_val;
        end
        return base;
    endfunction

    assign fwd_a = fwd(idex.rs, idex.op_a, mem_fwd_ok, exmem.rd, exmem.result,
                       wb_reg_w, wb_rd, wb_data);
    assign fwd_b = fwd(idex.rt, idex.op_b, mem_fwd_ok, exmem.rd, exmem.result,
                       wb_reg_w, wb_rd, wb_data);

    //////////////////////////////////////////////////
    // ALU and shifter
    //////////////////////////////////////////////////

    assign alu_b = idex.use_imm ? idex.imm : fwd_b;
    // Shamt field sits inside the immediate
    assign shamt = idex.imm[10:6];

    always_comb begin
        case (idex.alu_op)
            alu_add:      alu_out = fwd_a + alu_b;
            alu_sub:      alu_out = fwd_a - alu_b;
            alu_and:      alu_out = fwd_a & alu_b;
            alu_or:       alu_out = fwd_a | alu_b;
            alu_xor:      alu_out = fwd_a ^ alu_b;
            // Signed compare
            alu_slt:      alu_out = {31'd0, $signed(fwd_a) < $signed(alu_b)};
            alu_sll:      alu_out = alu_b << shamt;
            alu_srl:      alu_out = alu_b >> shamt;
            // Sign bit replicated
            alu_sra:      alu_out = word_t'($signed(alu_b) >>> shamt);
            alu_lui_pass: alu_out = {idex.imm[15:0], 16'h0000};
            default:      alu_out = '0;
        endcase
    end

    // EX/MEM control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exmem.valid <= 1'b0;
            exmem.reg_w <= 1'b0;
            exmem.mem_r <= 1'b0;
            exmem.mem_w <= 1'b0;
        end else begin
            exmem.valid <= idex.valid;
            exmem.reg_w <= idex.reg_w;
            exmem.mem_r <= idex.mem_r;
            exmem.mem_w <= idex.mem_w;
        end
    end

    // EX/MEM payload, store data is the forwarded rt
    always_ff @(posedge clk) begin
        exmem.result     <= alu_out;
        exmem.store_data <= fwd_b;
        exmem.rd         <= idex.rd;
    end

endmodule

`default_nettype wire

// ==== hw/mem_wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage import cpu_pkg::*; #(
    parameter int DMEM_WORDS = DMEM_WORDS_DEF
) (
    input  wire logic clk,
    input  wire logic rst_n,
    exmem_if.consumer exmem,
    output logic      wb_reg_w,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    // Index width, at least one bit
    localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    word_t          dmem [DMEM_WORDS];
    logic [29:0]    word_idx;
    logic [AW-1:0]  dmem_addr;
    word_t          load_data;

    //////////////////////////////////////////////////
    // Data memory
    //////////////////////////////////////////////////

    // Word address, wraps at the memory depth
    assign word_idx  = exmem.result[31:2];
    assign dmem_addr = AW'(word_idx % 30'(DMEM_WORDS));

    // Combinational read in MEM
    assign load_data = dmem[dmem_addr];

    // Write on the edge leaving MEM
    always_ff @(posedge clk) begin
        if (exmem.valid && exmem.mem_w) begin
            dmem[dmem_addr] <= exmem.store_data;
        end
    end

    //////////////////////////////////////////////////
    // MEM/WB register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_reg_w <= 1'b0;
        end else begin
            wb_reg_w <= exmem.valid && exmem.reg_w;
        end
    end

    // Loads take memory data, all others the ALU result
    always_ff @(posedge clk) begin
        wb_rd   <= exmem.rd;
        wb_data <= exmem.mem_r ? load_data : exmem.result;
    end

endmodule

`default_nettype wire

// ==== hw/pipeline_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipeline_top import cpu_pkg::*; #(
    parameter int DMEM_WORDS = DMEM_WORDS_DEF
) (
    input  wire logic clk,
    input  wire logic rst_n,
    // Instruction stream
    input  wire logic in_valid,
    input  word_t     in_instr,
    output logic      in_ready,
    // Write-back report
    output logic      commit_valid,
    output reg_addr_t commit_rd,
    output word_t     commit_data
);

    // Register file read path
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    // Write-back path
    logic      wb_reg_w;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // Stage bundles
    idex_if  idex_bus ();
    exmem_if exmem_bus ();

    decode_stage u_decode (
        .clk      ( clk ),
        .rst_n    ( rst_n ),
        .in_valid ( in_valid ),
        .in_instr ( in_instr ),
        .in_ready ( in_ready ),
        .rs_addr  ( rs_addr ),
        .rt_addr  ( rt_addr ),
        .rs_data  ( rs_data ),
        .rt_data  ( rt_data ),
        .idex     ( idex_bus.producer )
    );

    reg_file u_reg_file (
        .clk      ( clk ),
        .rst_n    ( rst_n ),
        .rs_addr  ( rs_addr ),
        .rt_addr  ( rt_addr ),
        .wb_reg_w ( wb_reg_w ),
        .wb_rd    ( wb_rd ),
        .wb_data  ( wb_data ),
        .rs_data  ( rs_data ),
        .rt_data  ( rt_data )
    );

    execute_stage u_execute (
        .clk      ( clk ),
        .rst_n    ( rst_n ),
        .wb_reg_w ( wb_reg_w ),
        .wb_rd    ( wb_rd ),
        .wb_data  ( wb_data ),
        .idex     ( idex_bus.consumer ),
        .exmem    ( exmem_bus.producer )
    );

    mem_wb_stage #(
        .DMEM_WORDS ( DMEM_WORDS )
    ) u_mem_wb (
        .clk      ( clk ),
        .rst_n    ( rst_n ),
        .exmem    ( exmem_bus.consumer ),
        .wb_reg_w ( wb_reg_w ),
        .wb_rd    ( wb_rd ),
        .wb_data  ( wb_data )
    );

    // Every register write is a commit
    assign commit_valid = wb_reg_w;
    assign commit_rd    = wb_rd;
    assign commit_data  = wb_data;

endmodule

`default_nettype wire

// ==== tb/pipeline_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipeline_asserts import cpu_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic in_valid,
    input  word_t     in_instr,
    input  wire logic in_ready,
    input  wire logic commit_valid,
    input  reg_addr_t commit_rd
);

    // Pending transfer holds valid and the word
    in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_instr)))
        else $error("in_valid or in_instr changed while a transfer was pending");

    // r0 writes never reach the commit port
    commit_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> (commit_rd != '0))
        else $error("commit_valid high with commit_rd zero");

    // Load-use stall lasts one cycle
    single_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !in_ready |=> in_ready)
        else $error("in_ready low for two cycles in a row");

endmodule

bind pipeline_top pipeline_asserts u_asserts (
    .clk          ( clk ),
    .rst_n        ( rst_n ),
    .in_valid     ( in_valid ),
    .in_instr     ( in_instr ),
    .in_ready     ( in_ready ),
    .commit_valid ( commit_valid ),
    .commit_rd    ( commit_rd )
);

`default_nettype wire

// ==== tb/tb_pipeline.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_pipeline import cpu_pkg::*; ();

    localparam int    READY_TIMEOUT = 20;
    localparam int    DRAIN_TIMEOUT = 40;
    localparam int    TAIL_CYCLES   = 8;
    localparam string PATTERN_FILE  = "tb/pipeline_patterns.txt";

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    word_t       in_instr;
    logic        in_ready;
    logic        commit_valid;
    reg_addr_t   commit_rd;
    word_t       commit_data;

    // Stimulus and expected commits, in file order
    word_t       instr_q [$];
    logic        tight_q [$];
    reg_addr_t   exp_rd_q [$];
    word_t       exp_data_q [$];

    int          value_errs;
    int          other_errs;
    int          stall_cycles;
    logic [31:0] lcg_state;

    pipeline_top #(
        .DMEM_WORDS ( DMEM_WORDS_DEF )
    ) u_dut (
        .clk          ( clk ),
        .rst_n        ( rst_n ),
        .in_valid     ( in_valid ),
        .in_instr     ( in_instr ),
        .in_ready     ( in_ready ),
        .commit_valid ( commit_valid ),
        .commit_rd    ( commit_rd ),
        .commit_data  ( commit_data )
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // LCG for idle gaps
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic load_patterns();
        int    fd;
        int    n;
        string line;
        string rest;
        byte   kind;
        word_t f1;
        word_t f2;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            other_errs++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2) begin
                continue;
            end
            kind = line.getc(0);
            if (kind == "#") begin
                continue;
            end
            rest = line.substr(1, line.len() - 1);
            n    = $sscanf(rest, "%h %h", f1, f2);
            // Trailing mnemonic text is ignored
            if ((kind == "I" || kind == "T") && n >= 1) begin
                instr_q.push_back(f1);
                tight_q.push_back(kind == "T");
            end else if (kind == "C" && n == 2) begin
                exp_rd_q.push_back(f1[4:0]);
                exp_data_q.push_back(f2);
            end else begin
                $display("Malformed pattern line: %s", line);
                other_errs++;
            end
        end
        $fclose(fd);
    endtask

    // Called 1 ns after an edge, returns 1 ns after the transfer edge
    task automatic send_instr(word_t instr);
        int waited;
        in_valid = 1'b1;
        in_instr = instr;
        waited   = 0;
        // in_ready ignores in_valid, already settled here
        while (!in_ready && waited < READY_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (in_ready) else begin
            $display("Timed out after %0d cycles waiting for in_ready", waited);
            other_errs++;
        end
        @(posedge clk);
        #1;
    endtask

    // In-order commit compare
    function automatic void check_commit();
        reg_addr_t exp_rd;
        word_t     exp_data;
        assert (exp_rd_q.size() != 0) else begin
            $display("Commit to register %0d arrived when none was expected", commit_rd);
            other_errs++;
        end
        if (exp_rd_q.size() != 0) begin
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            assert (commit_rd == exp_rd) else begin
                $display("ERR commit_rd got %h expected %h", commit_rd, exp_rd);
                value_errs++;
            end
            assert (commit_data == exp_data) else begin
                $display("ERR commit_data got %h expected %h", commit_data, exp_data);
                value_errs++;
            end
        end
    endfunction

    //////////////////////////////////////////////////
    // Monitor
    //////////////////////////////////////////////////

    // Mid-cycle sampling, outputs are registered
    always @(negedge clk) begin
        if (rst_n) begin
            if (!in_ready) begin
                stall_cycles++;
            end
            if (commit_valid) begin
                check_commit();
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        int          waited;
        word_t       instr;
        logic        tight;
        logic [31:0] r;
        in_valid     = 1'b0;
        in_instr     = '0;
        rst_n        = 1'b0;
        value_errs   = 0;
        other_errs   = 0;
        stall_cycles = 0;
        lcg_state    = 32'd65243;
        load_patterns();

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle pipeline right after reset
        assert (in_ready === 1'b1) else begin
            $display("ERR in_ready got %h expected %h", in_ready, 1'b1);
            value_errs++;
        end
        assert (commit_valid === 1'b0) else begin
            $display("ERR commit_valid got %h expected %h", commit_valid, 1'b0);
            value_errs++;
        end

        while (instr_q.size() != 0) begin
            instr = instr_q.pop_front();
            tight = tight_q.pop_front();
            r     = next_rand();
            // About one idle cycle in four
            if (!tight && r[31:30] == 2'b00) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            send_instr(instr);
        end
        in_valid = 1'b0;

        // Drain the pipeline
        waited = 0;
        while (exp_rd_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_rd_q.size() == 0) else begin
            $display("Timed out with %0d expected commits still missing", exp_rd_q.size());
            other_errs++;
        end

        // Stray commits show up in the monitor
        repeat (TAIL_CYCLES) @(posedge clk);

        // Exactly one lw feeds the next instruction
        assert (stall_cycles == 1) else begin
            $display("in_ready was low for %0d cycles instead of one load-use stall",
                     stall_cycles);
            other_errs++;
        end

        $display("Error counts: %0d value mismatches, %0d other failures",
                 value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/pipeline_patterns.txt ====
# Kind I sends the instruction word in column 2 after an optional idle cycle
# Kind T sends the instruction word in column 2 with no idle cycle before it
# Kind C expects a commit of register column 2 with data column 3
# Immediates and forwarding at short distance
I 3C011234 lui r1 0x1234
C 01 12340000
T 34215678 ori r1 r1 0x5678
C 01 12345678
I 2002FFFF addi r2 r0 -1
C 02 FFFFFFFF
T 30448F0F andi r4 r2 0x8f0f
C 04 00008F0F
T 00223020 add r6 r1 r2
C 06 12345677
T 00043822 sub r7 r0 r4
C 07 FFFF70F1
T 00265026 xor r10 r1 r6
C 0A 0000000F
# Logic, compare and shifts
I 0044582A slt r11 r2 r4
C 0B 00000001
I 00244024 and r8 r1 r4
C 08 00000608
I 00814825 or r9 r4 r1
C 09 1234DF7F
I 00016900 sll r13 r1 4
C 0D 23456780
I 00027202 srl r14 r2 8
C 0E 00FFFFFF
T 00077903 sra r15 r7 4
C 0F FFFFF70F
# Register zero and an unknown opcode
I 20000055 addi r0 r0 0x55
T 0002A025 or r20 r0 r2
C 14 FFFFFFFF
I FFFFFFFF unknown opcode
# Store, load and a load-use pair
I AC010008 sw r1 8(r0)
I 8C160008 lw r22 8(r0)
C 16 12345678
T 02D6B820 add r23 r22 r22
C 17 2468ACF0

// ==== build.f ====
hw/cpu_pkg.sv
hw/pipe_ifs.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/pipeline_top.sv
tb/pipeline_asserts.sv
tb/tb_pipeline.sv

// ==== Makefile ====
# Verilator simulation of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_pipeline
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

# Build and run, fail unless the pass line appears
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
